//--- design/seq_types_pkg.sv
package seq_types_pkg;

	// one sequence byte carried in each packet
	typedef logic [7:0] aux_t;

	// segment repeat count, same width as segment_number_max
	typedef logic [15:0] seg_count_t;

	// byte offset inside a packet
	typedef logic [15:0] byte_pos_t;

	// statistics counters and loss values
	typedef logic [31:0] stat_t;

	// --------------------
	// monitor state machine
	// --------------------
	// st_idle  waiting for first aux
	// st_run   checking each aux
	// st_done  packet limit reached, frozen until reset
	typedef enum logic [1:0] {
		st_idle = 2'd0,
		st_run  = 2'd1,
		st_done = 2'd2
	} monitor_state_t;

endpackage

//--- design/seq_config_pkg.sv
package seq_config_pkg;

	// aux byte position inside a packet
	localparam int DEFAULT_AUX_OFFSET = 0;

	// packets counted before the monitor stops
	localparam int DEFAULT_MAX_PACKETS = 500000;

	// loss pipeline depth, request to loss_valid
	localparam int LOSS_LATENCY = 3;

endpackage

//--- design/loss_req_if.sv
`timescale 1ns/1ns

interface loss_req_if;
	import seq_types_pkg::*;

	// one-cycle request pulse
	logic req;
	// aux before the mismatch
	aux_t aux_prev;
	// repeats already seen of aux_prev
	seg_count_t same_count;
	// aux that broke the sequence
	aux_t aux_new;

	modport ctrl (output req, aux_prev, same_count, aux_new);

	modport calc (input req, aux_prev, same_count, aux_new);

endinterface

//--- design/stats_if.sv
`timescale 1ns/1ns

interface stats_if;
	import seq_types_pkg::*;

	// judged packet strobe and its verdict
	logic check_strobe;
	logic check_ok;
	// first aux after reset, counted only
	logic seed;
	// loss pipeline result
	logic loss_valid;
	stat_t loss_value;

	modport ctrl (output check_strobe, check_ok, seed);
	modport calc (output loss_valid, loss_value);
	modport stats (input check_strobe, check_ok, seed, loss_valid, loss_value);

endinterface

//--- design/aux_extractor.sv
`timescale 1ns/1ns

module aux_extractor #(
	parameter int AUX_OFFSET = seq_config_pkg::DEFAULT_AUX_OFFSET
) (
	input logic clk,
	input logic rst,
	input logic rx_en,
	input seq_types_pkg::aux_t rx_data,
	output logic aux_strobe,
	output seq_types_pkg::aux_t aux_value
);
	import seq_types_pkg::*;

	// position of the byte currently on rx_data
	byte_pos_t byte_pos;
	logic at_aux;

	assign at_aux = rx_en && (byte_pos == byte_pos_t'(AUX_OFFSET));

	// --------------------
	// byte position
	// --------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			byte_pos <= '0;
		end else if (!rx_en) begin
			// idle between packets, next byte is offset 0
			byte_pos <= '0;
		end else if (byte_pos != '1) begin
			// saturate so very long packets never hit the offset twice
			byte_pos <= byte_pos + byte_pos_t'(1);
		end
	end

	// strobe one cycle after the aux byte
	always_ff @(posedge clk) begin
		if (rst) begin
			aux_strobe <= 1'b0;
		end else begin
			aux_strobe <= at_aux;
		end
	end

	// aux capture, qualified by aux_strobe
	always_ff @(posedge clk) begin
		if (at_aux) begin
			aux_value <= rx_data;
		end
	end

endmodule

//--- design/seq_check_ctrl.sv
`timescale 1ns/1ns

module seq_check_ctrl #(
	parameter int MAX_PACKETS = seq_config_pkg::DEFAULT_MAX_PACKETS
) (
	input logic clk,
	input logic rst,
	input seq_types_pkg::seg_count_t segment_number_max,
	input logic aux_strobe,
	input seq_types_pkg::aux_t aux_value,
	loss_req_if.ctrl loss_req,
	stats_if.ctrl stats,
	input seq_types_pkg::stat_t count_in,
	output logic valid,
	output seq_types_pkg::monitor_state_t state
);
	import seq_types_pkg::*;

	aux_t aux_prev;
	seg_count_t same_count;

	// last repeat of the current aux run
	logic run_last;
	aux_t aux_expect;
	logic aux_match;
	logic limit_hit;

	assign run_last = (same_count == segment_number_max - seg_count_t'(1));
	assign aux_expect = run_last ? aux_prev + aux_t'(1) : aux_prev;
	assign aux_match = (aux_value == aux_expect);
	assign limit_hit = (count_in >= stat_t'(MAX_PACKETS));

	// --------------------
	// state machine
	// --------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
			valid <= 1'b0;
			same_count <= '0;
			loss_req.req <= 1'b0;
			stats.check_strobe <= 1'b0;
			stats.seed <= 1'b0;
		end else begin
			// strobes are single cycle
			loss_req.req <= 1'b0;
			stats.check_strobe <= 1'b0;
			stats.seed <= 1'b0;
			case (state)
				st_idle: begin
					if (aux_strobe) begin
						// first aux only seeds the predictor
						aux_prev <= aux_value;
						same_count <= '0;
						stats.seed <= 1'b1;
						valid <= 1'b1;
						state <= st_run;
					end
				end
				st_run: begin
					// limit wins over a strobe in the same cycle
					if (limit_hit) begin
						state <= st_done;
					end else if (aux_strobe) begin
						stats.check_strobe <= 1'b1;
						stats.check_ok <= aux_match;
						aux_prev <= aux_value;
						if (aux_match) begin
							same_count <= run_last ? '0 : same_count + seg_count_t'(1);
						end else begin
							same_count <= '0;
							// surplus repeat of aux_prev loses nothing
							loss_req.req <= (aux_value != aux_prev);
							loss_req.aux_prev <= aux_prev;
							loss_req.same_count <= same_count;
							loss_req.aux_new <= aux_value;
						end
					end
				end
				st_done: begin
					// frozen until reset
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

endmodule

//--- design/loss_calculator.sv
`timescale 1ns/1ns

module loss_calculator (
	input logic clk,
	input logic rst,
	input seq_types_pkg::seg_count_t segment_number_max,
	loss_req_if.calc loss_req,
	stats_if.calc stats
);
	import seq_types_pkg::*;
	import seq_config_pkg::*;

	// one valid bit per stage, bit 0 is stage 1
	logic [LOSS_LATENCY-1:0] stage_vld;

	// rest of the broken run, and whole runs skipped
	seg_count_t part_seg;
	aux_t gap;

	stat_t s1_partial;
	aux_t s1_gap;
	stat_t s2_partial;
	stat_t s2_product;
	stat_t s3_sum;

	assign part_seg = segment_number_max - loss_req.same_count - seg_count_t'(1);
	// mod 256 wrap comes from the byte width
	assign gap = loss_req.aux_new - loss_req.aux_prev - aux_t'(1);

	always_ff @(posedge clk) begin
		if (rst) begin
			stage_vld <= '0;
		end else begin
			stage_vld <= {stage_vld[LOSS_LATENCY-2:0], loss_req.req};
		end
	end

	// --------------------
	// stage 1 partial segment and gap
	always_ff @(posedge clk) begin
		if (loss_req.req) begin
			s1_partial <= stat_t'(part_seg);
			s1_gap <= gap;
		end
	end

	// stage 2 whole runs times run length
	always_ff @(posedge clk) begin
		if (stage_vld[0]) begin
			s2_partial <= s1_partial;
			s2_product <= stat_t'(s1_gap) * stat_t'(segment_number_max);
		end
	end

	// stage 3 total
	always_ff @(posedge clk) begin
		if (stage_vld[1]) begin
			s3_sum <= s2_partial + s2_product;
		end
	end

	assign stats.loss_valid = stage_vld[LOSS_LATENCY-1];
	assign stats.loss_value = s3_sum;

endmodule

//--- design/seq_stats.sv
`timescale 1ns/1ns

module seq_stats (
	input logic clk,
	input logic rst,
	stats_if.stats stats,
	output seq_types_pkg::stat_t count,
	output seq_types_pkg::stat_t ok,
	output seq_types_pkg::stat_t ng,
	output seq_types_pkg::stat_t lostnum
);
	import seq_types_pkg::*;

	// --------------------
	// packet counters
	// --------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			count <= '0;
			ok <= '0;
			ng <= '0;
		end else begin
			// seed and judged packets both count
			if (stats.seed || stats.check_strobe) begin
				count <= count + stat_t'(1);
			end
			// verdict only for judged packets
			if (stats.check_strobe) begin
				if (stats.check_ok) begin
					ok <= ok + stat_t'(1);
				end else begin
					ng <= ng + stat_t'(1);
				end
			end
		end
	end

	// --------------------
	// lost packet total
	// --------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			lostnum <= '0;
		end else if (stats.loss_valid) begin
			lostnum <= lostnum + stats.loss_value;
		end
	end

endmodule

//--- design/seq_monitor_top.sv
`timescale 1ns/1ns

module seq_monitor_top #(
	parameter int AUX_OFFSET = seq_config_pkg::DEFAULT_AUX_OFFSET,
	parameter int MAX_PACKETS = seq_config_pkg::DEFAULT_MAX_PACKETS
) (
	input logic clk,
	input logic rst,
	input seq_types_pkg::seg_count_t segment_number_max,
	input logic rx_en,
	input seq_types_pkg::aux_t rx_data,
	output seq_types_pkg::stat_t count,
	output seq_types_pkg::stat_t ok,
	output seq_types_pkg::stat_t ng,
	output seq_types_pkg::stat_t lostnum,
	output logic valid,
	output seq_types_pkg::monitor_state_t state
);

	// extractor to control
	logic aux_strobe;
	seq_types_pkg::aux_t aux_value;

	// ctrl to loss pipeline
	loss_req_if loss_req ();
	// verdicts and losses into the counters
	stats_if stats_bus ();

	// --------------------
	aux_extractor #(
		.AUX_OFFSET (AUX_OFFSET)
	) u_aux_extractor (
		.clk        (clk),
		.rst        (rst),
		.rx_en      (rx_en),
		.rx_data    (rx_data),
		.aux_strobe (aux_strobe),
		.aux_value  (aux_value)
	);

	// count fed back for the packet limit
	seq_check_ctrl #(
		.MAX_PACKETS (MAX_PACKETS)
	) u_seq_check_ctrl (
		.clk                (clk),
		.rst                (rst),
		.segment_number_max (segment_number_max),
		.aux_strobe         (aux_strobe),
		.aux_value          (aux_value),
		.loss_req           (loss_req.ctrl),
		.stats              (stats_bus.ctrl),
		.count_in           (count),
		.valid              (valid),
		.state              (state)
	);

	loss_calculator u_loss_calculator (
		.clk                (clk),
		.rst                (rst),
		.segment_number_max (segment_number_max),
		.loss_req           (loss_req.calc),
		.stats              (stats_bus.calc)
	);

	seq_stats u_seq_stats (
		.clk     (clk),
		.rst     (rst),
		.stats   (stats_bus.stats),
		.count   (count),
		.ok      (ok),
		.ng      (ng),
		.lostnum (lostnum)
	);

endmodule

//--- testbench/seq_monitor_ref.svh
`ifndef SEQ_MONITOR_REF_SVH
`define SEQ_MONITOR_REF_SVH

// expected counter values after a packet sequence
typedef struct packed {
	stat_t count;
	stat_t ok;
	stat_t ng;
	stat_t lostnum;
} expect_t;

// sent holds the aux of every packet long enough to carry one
function automatic expect_t model_counters(input aux_t sent[$], input seg_count_t seg_max,
		input int max_pkts);
	expect_t e;
	aux_t prev;
	aux_t want;
	int same;
	int gap;
	e = '0;
	prev = '0;
	same = 0;
	foreach (sent[i]) begin
		// nothing counts once the limit is reached
		if (e.count < stat_t'(max_pkts)) begin
			e.count = e.count + 1;
			if (i != 0) begin
				want = (same == int'(seg_max) - 1) ? aux_t'(prev + 8'd1) : prev;
				if (sent[i] == want) begin
					e.ok = e.ok + 1;
					same = (same == int'(seg_max) - 1) ? 0 : same + 1;
				end else begin
					e.ng = e.ng + 1;
					// rest of broken run plus whole runs skipped
					if (sent[i] != prev) begin
						gap = int'(aux_t'(sent[i] - prev - 8'd1));
						e.lostnum = e.lostnum + stat_t'(int'(seg_max) - same - 1)
							+ stat_t'(gap) * stat_t'(seg_max);
					end
					same = 0;
				end
			end
			prev = sent[i];
		end
	end
	return e;
endfunction

`endif

//--- testbench/tb_seq_monitor.sv
`timescale 1ns/1ns

module tb_seq_monitor;
	import seq_types_pkg::*;

	`include "seq_monitor_ref.svh"

	localparam int AUX_OFS = 2;
	localparam int MAX_PKTS = 60;
	localparam int CLK_PERIOD = 20;
	// packets sent over both runs
	localparam int PLANNED_PKTS = 86;

	logic clk;
	logic rst;
	seg_count_t segment_number_max;
	logic rx_en;
	aux_t rx_data;
	stat_t count;
	stat_t ok;
	stat_t ng;
	stat_t lostnum;
	logic valid;
	monitor_state_t state;

	aux_t sent[$];
	string scenario;
	int errors = 0;
	int checks = 0;
	int seed = 74;
	event scenario_end;
	event check_end;

	seq_monitor_top #(
		.AUX_OFFSET  (AUX_OFS),
		.MAX_PACKETS (MAX_PKTS)
	) dut (
		.clk (clk), .rst (rst), .segment_number_max (segment_number_max),
		.rx_en (rx_en), .rx_data (rx_data), .count (count), .ok (ok), .ng (ng),
		.lostnum (lostnum), .valid (valid), .state (state)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// --------------------
	// compare tasks
	task automatic compare_stat(input string name, input stat_t got, input stat_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH %s (%s) got 0x%h expected 0x%h", name, scenario, got, exp);
		end
	endtask

	task automatic compare_state(input string name, input monitor_state_t got,
			input monitor_state_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH %s (%s) got 0x%h expected 0x%h", name, scenario, got, exp);
		end
	endtask

	task automatic compare_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH %s (%s) got 0x%h expected 0x%h", name, scenario, got, exp);
		end
	endtask

	// --------------------
	// stimulus helpers
	// one packet with aux at AUX_OFS and random other bytes
	task automatic send_packet(input aux_t aux, input int len, input int gap);
		int i;
		for (i = 0; i < len; i++) begin
			@(negedge clk);
			rx_en = 1'b1;
			rx_data = (i == AUX_OFS) ? aux : aux_t'($urandom);
		end
		for (i = 0; i < gap; i++) begin
			@(negedge clk);
			rx_en = 1'b0;
			rx_data = '0;
		end
		// short packets never reach the aux byte
		if (len > AUX_OFS) sent.push_back(aux);
	endtask

	// n packets of random length and gap sharing one aux
	task automatic send_run(input aux_t aux, input int n);
		repeat (n) send_packet(aux, 3 + int'($urandom % 10), 1 + int'($urandom % 4));
	endtask

	task automatic apply_reset(input seg_count_t seg_max);
		rst = 1'b1;
		segment_number_max = seg_max;
		repeat (8) @(negedge clk);
		rst = 1'b0;
		sent.delete();
	endtask

	task automatic end_scenario(input string name);
		scenario = name;
		-> scenario_end;
		@(check_end);
	endtask

	// --------------------
	// checking process
	initial begin : check_results
		expect_t exp;
		monitor_state_t exp_state;
		forever begin
			@(scenario_end);
			// let the loss pipeline drain
			repeat (10) @(negedge clk);
			exp = model_counters(sent, segment_number_max, MAX_PKTS);
			if (exp.count >= stat_t'(MAX_PKTS)) exp_state = st_done;
			else if (exp.count != 0) exp_state = st_run;
			else exp_state = st_idle;
			compare_stat("count", count, exp.count);
			compare_stat("ok", ok, exp.ok);
			compare_stat("ng", ng, exp.ng);
			compare_stat("lostnum", lostnum, exp.lostnum);
			compare_bit("valid", valid, exp.count != 0);
			compare_state("state", state, exp_state);
			-> check_end;
		end
	end

	// watchdog allows 20 cycles for every packet sent
	initial begin
		#(PLANNED_PKTS * 20 * CLK_PERIOD);
		$display("timeout, stimulus did not finish in %0d ns", PLANNED_PKTS * 20 * CLK_PERIOD);
		$display("Checks failed");
		$finish;
	end

	// --------------------
	// scenarios
	initial begin : stimulus
		aux_t a;
		void'($urandom(seed));
		rst = 1'b1;
		rx_en = 1'b0;
		rx_data = '0;
		segment_number_max = 16'd4;
		apply_reset(16'd4);
		end_scenario("after reset");
		// clean runs wrapping 255 to 0
		for (int k = 0; k < 6; k++) send_run(aux_t'(8'hfc + k), 4);
		end_scenario("clean");
		compare_stat("ok", ok, stat_t'(sent.size() - 1));
		compare_stat("ng", ng, '0);
		compare_stat("lostnum", lostnum, '0);
		// one packet dropped then whole runs
		send_run(8'h02, 3);
		send_run(8'h03, 4);
		send_run(8'h06, 2);
		send_run(8'h07, 4);
		end_scenario("drops");
		send_run(8'h08, 6);
		send_run(8'h09, 4);
		end_scenario("repeats");
		send_packet(8'h55, 1, 2);
		send_packet(8'h66, 2, 1);
		send_run(8'h0a, 4);
		end_scenario("short packets");
		// mismatches as close together as a 3-byte packet allows
		send_packet(8'h20, 3, 1);
		send_packet(8'h40, 3, 1);
		send_packet(8'h60, 3, 1);
		send_packet(8'h80, 3, 1);
		end_scenario("back to back");
		send_run(8'h81, 5);
		end_scenario("limit reached");
		send_run(8'h82, 6);
		end_scenario("frozen");
		// second run with every aux used once
		apply_reset(16'd1);
		send_run(8'h10, 1);
		send_run(8'h11, 1);
		send_run(8'h13, 1);
		send_run(8'h13, 1);
		a = 8'h14;
		for (int k = 0; k < 14; k++) begin
			send_run(a, 1);
			a = a + aux_t'(1 + $urandom % 3);
		end
		end_scenario("segment max 1");
		$display("%0d errors in %0d checks", errors, checks);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

//--- list.f
+incdir+testbench
design/seq_types_pkg.sv
design/seq_config_pkg.sv
design/loss_req_if.sv
design/stats_if.sv
design/aux_extractor.sv
design/seq_check_ctrl.sv
design/loss_calculator.sv
design/seq_stats.sv
design/seq_monitor_top.sv
testbench/tb_seq_monitor.sv
